// ==== logic/amo_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module amo_alu (
    input  lsu_op_pkg::amoop_e      op_i,
    input  wire [`LSU_XLEN-1:0]     mem_i,
    input  wire [`LSU_XLEN-1:0]     src_i,
    output logic [`LSU_XLEN-1:0]    result_o
);

    logic mem_ltu;
    logic mem_lt;

    assign mem_ltu = mem_i < src_i;

    // the negative one is smaller when signs differ
    // equal signs keep the unsigned order
    assign mem_lt = (mem_i[`LSU_XLEN-1] != src_i[`LSU_XLEN-1]) ? mem_i[`LSU_XLEN-1] : mem_ltu;

    // new memory word
    always_comb begin
        case (op_i)
            lsu_op_pkg::AMOOP_SWAP: result_o = src_i;
            lsu_op_pkg::AMOOP_ADD:  result_o = mem_i + src_i;
            lsu_op_pkg::AMOOP_XOR:  result_o = mem_i ^ src_i;
            lsu_op_pkg::AMOOP_AND:  result_o = mem_i & src_i;
            lsu_op_pkg::AMOOP_OR:   result_o = mem_i | src_i;
            lsu_op_pkg::AMOOP_MIN:  result_o = mem_lt ? mem_i : src_i;
            lsu_op_pkg::AMOOP_MAX:  result_o = mem_lt ? src_i : mem_i;
            lsu_op_pkg::AMOOP_MINU: result_o = mem_ltu ? mem_i : src_i;
            lsu_op_pkg::AMOOP_MAXU: result_o = mem_ltu ? src_i : mem_i;
            // unused codes behave as swap
            default:                result_o = src_i;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/amo_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module amo_ctrl (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      start_i,
    input  lsu_op_pkg::memop_e       op_i,
    input  lsu_op_pkg::amoop_e       amo_op_i,
    input  wire [`LSU_XLEN-1:0]      addr_i,
    input  wire [`LSU_XLEN-1:0]      src_i,
    input  wire                      plain_store_i,
    input  dbus_pkg::dbus_rsp_t      dbus_rsp_i,
    output dbus_pkg::dbus_req_t      dbus_req_o,
    input  wire [`LSU_XLEN-1:0]      calc_i,
    output logic [`LSU_XLEN-1:0]     mem_o,
    output logic                     done_o,
    output logic [`LSU_XLEN-1:0]     result_o,
    output logic                     misalign_o
);

    // one-hot sequencer state
    typedef enum logic [3:0] {
        ST_IDLE  = 4'b0001,
        ST_LOAD  = 4'b0010,
        ST_CALC  = 4'b0100,
        ST_STORE = 4'b1000
    } state_e;

    state_e                 state_q;
    logic                   done_q;
    logic                   misalign_q;
    logic [`LSU_XLEN-1:0]   result_q;
    logic                   resv_valid_q;
    logic [`LSU_XLEN-1:0]   resv_addr_q;
    // old word and new word of a read-modify-write
    logic [`LSU_XLEN-1:0]   loaded_q;
    logic [`LSU_XLEN-1:0]   calc_q;

    logic is_lr;
    logic is_sc;
    logic aligned;
    logic sc_hit;
    logic accept;
    logic load_ack;

    assign is_lr    = op_i == lsu_op_pkg::MEMOP_LR_W;
    assign is_sc    = op_i == lsu_op_pkg::MEMOP_SC_W;
    assign aligned  = addr_i[1:0] == 2'b00;
    assign sc_hit   = resv_valid_q && (resv_addr_q == addr_i);
    // the done cycle still sees the old request and must not restart it
    assign accept   = start_i && !done_q && (state_q == ST_IDLE);
    assign load_ack = (state_q == ST_LOAD) && dbus_rsp_i.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= ST_IDLE;
            done_q       <= 1'b0;
            misalign_q   <= 1'b0;
            result_q     <= '0;
            resv_valid_q <= 1'b0;
        end else begin
            done_q     <= 1'b0;
            misalign_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        if (!aligned) begin
                            // refused with the reservation left alone
                            done_q     <= 1'b1;
                            misalign_q <= 1'b1;
                            result_q   <= '0;
                        end else if (is_sc && !sc_hit) begin
                            // failed SC gives no bus write
                            done_q       <= 1'b1;
                            result_q     <= 32'd1;
                            resv_valid_q <= 1'b0;
                        end else if (is_sc) begin
                            state_q <= ST_STORE;
                        end else begin
                            state_q <= ST_LOAD;
                        end
                    end
                end
                ST_LOAD: begin
                    if (dbus_rsp_i.ready) begin
                        if (is_lr) begin
                            result_q     <= dbus_rsp_i.rdata;
                            resv_valid_q <= 1'b1;
                            done_q       <= 1'b1;
                            state_q      <= ST_IDLE;
                        end else begin
                            state_q <= ST_CALC;
                        end
                    end
                end
                ST_CALC: begin
                    state_q <= ST_STORE;
                end
                ST_STORE: begin
                    if (dbus_rsp_i.ready) begin
                        // SC success gives 0 and an AMO gives the old word
                        result_q     <= is_sc ? '0 : loaded_q;
                        resv_valid_q <= 1'b0;
                        done_q       <= 1'b1;
                        state_q      <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
            // any completed plain store kills the reservation
            if (plain_store_i) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ack) begin
            loaded_q <= dbus_rsp_i.rdata;
        end
        if (load_ack && is_lr) begin
            resv_addr_q <= addr_i;
        end
        if (state_q == ST_CALC) begin
            calc_q <= calc_i;
        end
    end

    // own bus request is always a full word
    always_comb begin
        dbus_req_o.valid = (state_q == ST_LOAD) || (state_q == ST_STORE);
        dbus_req_o.we    = state_q == ST_STORE;
        dbus_req_o.addr  = {addr_i[`LSU_XLEN-1:2], 2'b00};
        dbus_req_o.wdata = is_sc ? src_i : calc_q;
        dbus_req_o.mask  = '1;
    end

    assign mem_o      = loaded_q;
    assign done_o     = done_q;
    assign result_o   = result_q;
    assign misalign_o = misalign_q;

    // legal encoding and busy only under a live atomic request
    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        $onehot(state_q) && ((state_q == ST_IDLE) || start_i));

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        done_q |=> !done_q);

    // ALU and bus fields depend on the request staying put while busy
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (state_q != ST_IDLE) |-> $stable({op_i, amo_op_i, addr_i, src_i}));

endmodule

`default_nettype wire

// ==== logic/dbus_pkg.sv ====
`default_nettype none

`include "lsu_consts.svh"

package dbus_pkg;

    // held by the requester until ready
    typedef struct packed {
        logic                    valid;
        logic                    we;
        // byte address whose low bits give the lane offset
        logic [`LSU_XLEN-1:0]    addr;
        // already placed in its byte lanes
        logic [`LSU_XLEN-1:0]    wdata;
        logic [`LSU_NBYTES-1:0]  mask;
    } dbus_req_t;

    // ready is a single-cycle pulse with rdata valid in that cycle
    typedef struct packed {
        logic                  ready;
        logic [`LSU_XLEN-1:0]  rdata;
    } dbus_rsp_t;

endpackage

`default_nettype wire

// ==== logic/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data path and address width of the stage
`define LSU_XLEN 32

// byte lanes in one bus word
`define LSU_NBYTES 4

// width of the stage operation code
`define LSU_MEMOP_W 4

// width of the AMO operation code
`define LSU_AMOOP_W 4

// cycles allowed per request before a run is called hung
`define LSU_TIMEOUT_CYC 40

`endif

// ==== logic/lsu_lanes.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_lanes (
    input  lsu_op_pkg::memop_e        op_i,
    input  wire [`LSU_XLEN-1:0]       addr_i,
    input  wire [`LSU_XLEN-1:0]       wdata_i,
    input  wire [`LSU_XLEN-1:0]       rdata_i,
    output logic [`LSU_NBYTES-1:0]    mask_o,
    output logic [`LSU_XLEN-1:0]      wdata_o,
    output logic                      we_o,
    output logic [`LSU_XLEN-1:0]      load_data_o
);

    // unshifted strobes for the access size
    logic [`LSU_NBYTES-1:0] size_mask;
    // bit offset of the addressed lane
    logic [4:0]             lane_shift;
    // read word moved down so the addressed lane sits at bit 0
    logic [`LSU_XLEN-1:0]   rdata_low;

    assign lane_shift = {addr_i[1:0], 3'b000};

    // size decode shared by loads and stores
    always_comb begin
        size_mask = '0;
        we_o      = 1'b0;
        case (op_i)
            lsu_op_pkg::MEMOP_LB,
            lsu_op_pkg::MEMOP_LBU: begin
                size_mask = 4'b0001;
            end
            lsu_op_pkg::MEMOP_LH,
            lsu_op_pkg::MEMOP_LHU: begin
                size_mask = 4'b0011;
            end
            lsu_op_pkg::MEMOP_LW: begin
                size_mask = 4'b1111;
            end
            lsu_op_pkg::MEMOP_SB: begin
                size_mask = 4'b0001;
                we_o      = 1'b1;
            end
            lsu_op_pkg::MEMOP_SH: begin
                size_mask = 4'b0011;
                we_o      = 1'b1;
            end
            lsu_op_pkg::MEMOP_SW: begin
                size_mask = 4'b1111;
                we_o      = 1'b1;
            end
            default: begin
                size_mask = '0;
                we_o      = 1'b0;
            end
        endcase
    end

    // strobes and store data follow the byte offset
    assign mask_o  = size_mask << addr_i[1:0];
    assign wdata_o = wdata_i << lane_shift;

    assign rdata_low = rdata_i >> lane_shift;

    // pick byte or halfword and extend it
    always_comb begin
        case (op_i)
            lsu_op_pkg::MEMOP_LB:  load_data_o = {{24{rdata_low[7]}}, rdata_low[7:0]};
            lsu_op_pkg::MEMOP_LBU: load_data_o = {24'h0, rdata_low[7:0]};
            lsu_op_pkg::MEMOP_LH:  load_data_o = {{16{rdata_low[15]}}, rdata_low[15:0]};
            lsu_op_pkg::MEMOP_LHU: load_data_o = {16'h0, rdata_low[15:0]};
            // word loads return the word shifted down by the offset
            default:               load_data_o = rdata_low;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/lsu_op_pkg.sv ====
`default_nettype none

`include "lsu_consts.svh"

package lsu_op_pkg;

    // stage operation where none means ALU result bypass
    typedef enum logic [`LSU_MEMOP_W-1:0] {
        MEMOP_NONE,
        MEMOP_LB,
        MEMOP_LBU,
        MEMOP_LH,
        MEMOP_LHU,
        MEMOP_LW,
        MEMOP_SB,
        MEMOP_SH,
        MEMOP_SW,
        MEMOP_LR_W,
        MEMOP_SC_W,
        MEMOP_AMO
    } memop_e;

    // read-modify-write flavour used only by MEMOP_AMO
    typedef enum logic [`LSU_AMOOP_W-1:0] {
        AMOOP_SWAP,
        AMOOP_ADD,
        AMOOP_XOR,
        AMOOP_AND,
        AMOOP_OR,
        AMOOP_MIN,
        AMOOP_MAX,
        AMOOP_MINU,
        AMOOP_MAXU
    } amoop_e;

    // request from the pipeline held until done
    typedef struct packed {
        memop_e                op;
        amoop_e                amo_op;
        // ALU result
        logic [`LSU_XLEN-1:0]  addr;
        // rs2
        logic [`LSU_XLEN-1:0]  wdata;
    } lsu_req_t;

endpackage

`default_nettype wire

// ==== logic/lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      valid_i,
    input  lsu_op_pkg::lsu_req_t     req_i,
    input  dbus_pkg::dbus_rsp_t      dbus_rsp_i,
    output dbus_pkg::dbus_req_t      dbus_req_o,
    output logic                     done_o,
    output logic [`LSU_XLEN-1:0]     result_o,
    output logic                     misalign_o,
    output logic                     stall_o
);

    logic is_plain;
    logic is_atomic;

    // plain path
    logic [`LSU_NBYTES-1:0] lane_mask;
    logic [`LSU_XLEN-1:0]   lane_wdata;
    logic                   lane_we;
    logic [`LSU_XLEN-1:0]   load_data;
    dbus_pkg::dbus_req_t    plain_req;
    logic                   plain_store_done;

    // atomic path
    dbus_pkg::dbus_req_t    amo_req;
    logic [`LSU_XLEN-1:0]   amo_mem;
    logic [`LSU_XLEN-1:0]   amo_calc;
    logic                   amo_done;
    logic [`LSU_XLEN-1:0]   amo_result;
    logic                   amo_misalign;

    always_comb begin
        is_plain  = 1'b0;
        is_atomic = 1'b0;
        case (req_i.op)
            lsu_op_pkg::MEMOP_LB,
            lsu_op_pkg::MEMOP_LBU,
            lsu_op_pkg::MEMOP_LH,
            lsu_op_pkg::MEMOP_LHU,
            lsu_op_pkg::MEMOP_LW,
            lsu_op_pkg::MEMOP_SB,
            lsu_op_pkg::MEMOP_SH,
            lsu_op_pkg::MEMOP_SW: is_plain = 1'b1;
            lsu_op_pkg::MEMOP_LR_W,
            lsu_op_pkg::MEMOP_SC_W,
            lsu_op_pkg::MEMOP_AMO: is_atomic = 1'b1;
            default: begin
                is_plain  = 1'b0;
                is_atomic = 1'b0;
            end
        endcase
    end

    lsu_lanes u_lanes (
        .op_i        (req_i.op),
        .addr_i      (req_i.addr),
        .wdata_i     (req_i.wdata),
        .rdata_i     (dbus_rsp_i.rdata),
        .mask_o      (lane_mask),
        .wdata_o     (lane_wdata),
        .we_o        (lane_we),
        .load_data_o (load_data)
    );

    // valid from the first cycle of the request
    always_comb begin
        plain_req.valid = valid_i && is_plain;
        plain_req.we    = lane_we;
        plain_req.addr  = req_i.addr;
        plain_req.wdata = lane_wdata;
        plain_req.mask  = lane_mask;
    end

    assign plain_store_done = plain_req.valid && lane_we && dbus_rsp_i.ready;

    amo_ctrl u_amo_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start_i       (valid_i && is_atomic),
        .op_i          (req_i.op),
        .amo_op_i      (req_i.amo_op),
        .addr_i        (req_i.addr),
        .src_i         (req_i.wdata),
        .plain_store_i (plain_store_done),
        .dbus_rsp_i    (dbus_rsp_i),
        .dbus_req_o    (amo_req),
        .calc_i        (amo_calc),
        .mem_o         (amo_mem),
        .done_o        (amo_done),
        .result_o      (amo_result),
        .misalign_o    (amo_misalign)
    );

    amo_alu u_amo_alu (
        .op_i     (req_i.amo_op),
        .mem_i    (amo_mem),
        .src_i    (req_i.wdata),
        .result_o (amo_calc)
    );

    // bus owner follows the request class
    assign dbus_req_o = is_atomic ? amo_req : plain_req;

    always_comb begin
        if (is_atomic) begin
            done_o   = amo_done;
            result_o = amo_result;
        end else if (is_plain) begin
            done_o   = plain_req.valid && dbus_rsp_i.ready;
            result_o = load_data;
        end else begin
            // ALU bypass is done at once
            // unknown codes fall back to it too
            done_o   = valid_i;
            result_o = req_i.addr;
        end
    end

    assign misalign_o = is_atomic && amo_misalign;
    assign stall_o    = valid_i && !done_o;

    // bus request stays frozen through wait states while the pipeline holds
    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        (dbus_req_o.valid && !dbus_rsp_i.ready) |=> $stable(dbus_req_o));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f sim.f --top-module tb_lsu -o tb_lsu &&
./obj_dir/tb_lsu | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+logic
logic/lsu_op_pkg.sv
logic/dbus_pkg.sv
logic/lsu_lanes.sv
logic/amo_alu.sv
logic/amo_ctrl.sv
logic/lsu_top.sv
tests/dmem_model.sv
tests/tb_lsu.sv

// ==== tests/dmem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module dmem_model (
    input  wire                   clk,
    input  wire                   rst,
    input  dbus_pkg::dbus_req_t   req_i,
    output dbus_pkg::dbus_rsp_t   rsp_o
);

    // 64 words read directly by the checker
    logic [`LSU_XLEN-1:0] mem [0:63];
    // cycles waited so far and the wait picked for this access
    logic [1:0]           wait_q;
    logic [1:0]           lat_q;
    logic [5:0]           idx;

    assign idx         = req_i.addr[7:2];
    assign rsp_o.ready = req_i.valid && (wait_q == lat_q);
    assign rsp_o.rdata = mem[idx];

    // fill depends on every address bit
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h6b3c_0000 ^ (32'(i) * 32'h0001_0203);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_q <= 2'd0;
            lat_q  <= 2'd0;
        end else if (rsp_o.ready) begin
            wait_q <= 2'd0;
            // next access gets 0 to 3 wait cycles
            lat_q  <= 2'($urandom % 4);
            if (req_i.we) begin
                for (int b = 0; b < `LSU_NBYTES; b++) begin
                    if (req_i.mask[b]) begin
                        mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end
        end else if (req_i.valid) begin
            wait_q <= wait_q + 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "lsu_consts.svh"

module tb_lsu;

    localparam int NUM_REQ = 101;
    localparam int LIMIT   = `LSU_TIMEOUT_CYC * NUM_REQ;

    logic                  clk;
    logic                  rst;
    logic                  valid;
    lsu_op_pkg::lsu_req_t  req;
    dbus_pkg::dbus_req_t   dbus_req;
    dbus_pkg::dbus_rsp_t   dbus_rsp;
    logic                  done;
    logic [31:0]           result;
    logic                  misalign;
    logic                  stall;

    // reference state
    logic [31:0] ref_mem [0:63];
    logic        resv_valid;
    logic [31:0] resv_addr;

    // expectations of the request in flight
    logic [31:0] exp_res;
    logic        exp_mis;
    logic        chk_res;
    logic        exp_nobus;
    logic [3:0]  exp_mask;
    logic [5:0]  exp_idx;
    logic [31:0] exp_word;
    logic [31:0] mirror_word;

    int errors;
    int timeouts;
    int cycles;

    lsu_top DUT (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid),
        .req_i      (req),
        .dbus_rsp_i (dbus_rsp),
        .dbus_req_o (dbus_req),
        .done_o     (done),
        .result_o   (result),
        .misalign_o (misalign),
        .stall_o    (stall)
    );

    dmem_model u_mem (
        .clk   (clk),
        .rst   (rst),
        .req_i (dbus_req),
        .rsp_o (dbus_rsp)
    );

    assign mirror_word = u_mem.mem[exp_idx];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            timeouts = timeouts + 1;
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("errors=%0d timeouts=%0d", errors, timeouts);
            $display("Result: FAILED");
            $finish;
        end
    end

    a_result: assert property (@(posedge clk) disable iff (rst)
        (done && chk_res) |-> result == exp_res)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t result_o got %h exp %h", $time, $sampled(result),
                     exp_res);
        end

    a_misalign: assert property (@(posedge clk) disable iff (rst)
        done |-> misalign == exp_mis)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t misalign_o got %b exp %b", $time, $sampled(misalign),
                     exp_mis);
        end

    // word in memory one cycle after done
    a_mem: assert property (@(posedge clk) disable iff (rst)
        done |=> mirror_word == exp_word)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t mem[%0d] got %h exp %h", $time, exp_idx,
                     $sampled(mirror_word), exp_word);
        end

    a_mask: assert property (@(posedge clk) disable iff (rst)
        dbus_req.valid |-> dbus_req.mask == exp_mask)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t dbus mask got %b exp %b", $time,
                     $sampled(dbus_req.mask), exp_mask);
        end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        valid |-> stall == !done)
        else begin
            errors = errors + 1;
            $display("CHECK FAILED t=%0t stall_o got %b exp %b", $time, $sampled(stall),
                     !$sampled(done));
        end

    a_hold: assert property (@(posedge clk) disable iff (rst)
        (dbus_req.valid && !dbus_rsp.ready) |=> $stable(dbus_req))
        else begin
            errors = errors + 1;
            $display("bus request changed while waiting for ready at t=%0t", $time);
        end

    a_nobus: assert property (@(posedge clk) disable iff (rst)
        (valid && exp_nobus) |-> !dbus_req.valid)
        else begin
            errors = errors + 1;
            $display("bus access seen where none was allowed at t=%0t", $time);
        end

    function automatic logic [31:0] load_ref(input logic [31:0] w, input logic [1:0] off,
                                             input int nb, input logic sx);
        logic [31:0] s;
        s = w >> (8 * off);
        if (nb == 1) begin
            return sx ? {{24{s[7]}}, s[7:0]} : {24'h0, s[7:0]};
        end
        if (nb == 2) begin
            return sx ? {{16{s[15]}}, s[15:0]} : {16'h0, s[15:0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] w, input logic [1:0] off,
                                                input int nb, input logic [31:0] d);
        logic [31:0] r;
        r = w;
        for (int b = 0; b < nb; b++) begin
            r[8*(off+b) +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    function automatic logic [31:0] amo_ref(input lsu_op_pkg::amoop_e op, input logic [31:0] m,
                                            input logic [31:0] s);
        case (op)
            lsu_op_pkg::AMOOP_ADD:  return m + s;
            lsu_op_pkg::AMOOP_XOR:  return m ^ s;
            lsu_op_pkg::AMOOP_AND:  return m & s;
            lsu_op_pkg::AMOOP_OR:   return m | s;
            lsu_op_pkg::AMOOP_MIN:  return ($signed(m) < $signed(s)) ? m : s;
            lsu_op_pkg::AMOOP_MAX:  return ($signed(m) > $signed(s)) ? m : s;
            lsu_op_pkg::AMOOP_MINU: return (m < s) ? m : s;
            lsu_op_pkg::AMOOP_MAXU: return (m > s) ? m : s;
            default:                return s;
        endcase
    endfunction

    // model the request and drive it until done
    task automatic run_req(input lsu_op_pkg::memop_e op, input lsu_op_pkg::amoop_e aop,
                           input logic [31:0] addr, input logic [31:0] data);
        logic [5:0]  idx;
        logic [1:0]  off;
        logic [31:0] old;
        logic [31:0] res;
        logic        mis;
        logic        nobus;
        logic        is_store;
        logic [3:0]  size_mask;
        int          nb;
        idx      = addr[7:2];
        off      = addr[1:0];
        old      = ref_mem[idx];
        res      = '0;
        mis      = 1'b0;
        nobus    = 1'b0;
        is_store = 1'b0;
        nb       = 4;
        case (op)
            lsu_op_pkg::MEMOP_NONE: begin
                // bypass returns the address untouched
                res   = addr;
                nobus = 1'b1;
            end
            lsu_op_pkg::MEMOP_LB: begin
                nb  = 1;
                res = load_ref(old, off, 1, 1'b1);
            end
            lsu_op_pkg::MEMOP_LBU: begin
                nb  = 1;
                res = load_ref(old, off, 1, 1'b0);
            end
            lsu_op_pkg::MEMOP_LH: begin
                nb  = 2;
                res = load_ref(old, off, 2, 1'b1);
            end
            lsu_op_pkg::MEMOP_LHU: begin
                nb  = 2;
                res = load_ref(old, off, 2, 1'b0);
            end
            lsu_op_pkg::MEMOP_LW:  res = old;
            lsu_op_pkg::MEMOP_SB,
            lsu_op_pkg::MEMOP_SH,
            lsu_op_pkg::MEMOP_SW: begin
                nb = (op == lsu_op_pkg::MEMOP_SB) ? 1 : (op == lsu_op_pkg::MEMOP_SH) ? 2 : 4;
                is_store     = 1'b1;
                ref_mem[idx] = store_merge(old, off, nb, data);
                resv_valid   = 1'b0;
            end
            default: begin
                // word atomics
                if (off != 2'b00) begin
                    mis   = 1'b1;
                    nobus = 1'b1;
                end else if (op == lsu_op_pkg::MEMOP_LR_W) begin
                    res        = old;
                    resv_valid = 1'b1;
                    resv_addr  = addr;
                end else if (op == lsu_op_pkg::MEMOP_SC_W) begin
                    if (resv_valid && resv_addr == addr) begin
                        ref_mem[idx] = data;
                        res          = 32'd0;
                    end else begin
                        res   = 32'd1;
                        nobus = 1'b1;
                    end
                    resv_valid = 1'b0;
                end else begin
                    res          = old;
                    ref_mem[idx] = amo_ref(aop, old, data);
                    resv_valid   = 1'b0;
                end
            end
        endcase
        size_mask = (nb == 1) ? 4'b0001 : (nb == 2) ? 4'b0011 : 4'b1111;
        @(posedge clk);
        req.op    <= op;
        req.amo_op <= aop;
        req.addr  <= addr;
        req.wdata <= data;
        valid     <= 1'b1;
        exp_res   <= res;
        exp_mis   <= mis;
        chk_res   <= !is_store && !mis;
        exp_nobus <= nobus;
        exp_mask  <= size_mask << off;
        exp_idx   <= idx;
        exp_word  <= ref_mem[idx];
        // done sampled mid-cycle away from the edge
        do begin
            @(negedge clk);
        end while (!done);
        @(posedge clk);
        valid <= 1'b0;
    endtask

    initial begin
        logic [31:0] m;
        logic [31:0] s;
        void'($urandom(32'h109a_3d49));
        rst        = 1'b1;
        valid      = 1'b0;
        req        = '0;
        errors     = 0;
        timeouts   = 0;
        cycles     = 0;
        resv_valid = 1'b0;
        resv_addr  = '0;
        exp_res    = '0;
        exp_mis    = 1'b0;
        chk_res    = 1'b0;
        exp_nobus  = 1'b0;
        exp_mask   = '0;
        exp_idx    = '0;
        exp_word   = '0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = 32'h6b3c_0000 ^ (32'(i) * 32'h0001_0203);
        end
        exp_word = ref_mem[0];
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // byte and halfword stores merged into a word
        for (int off = 0; off < 4; off++) begin
            run_req(lsu_op_pkg::MEMOP_SW, lsu_op_pkg::AMOOP_SWAP, 32'h10, $urandom);
            run_req(lsu_op_pkg::MEMOP_SB, lsu_op_pkg::AMOOP_SWAP, 32'(16 + off), $urandom);
            run_req(lsu_op_pkg::MEMOP_LW, lsu_op_pkg::AMOOP_SWAP, 32'h10, 32'h0);
        end
        for (int off = 0; off < 3; off++) begin
            run_req(lsu_op_pkg::MEMOP_SW, lsu_op_pkg::AMOOP_SWAP, 32'h14, $urandom);
            run_req(lsu_op_pkg::MEMOP_SH, lsu_op_pkg::AMOOP_SWAP, 32'(20 + off), $urandom);
            run_req(lsu_op_pkg::MEMOP_LW, lsu_op_pkg::AMOOP_SWAP, 32'h14, 32'h0);
        end

        // sub-word loads over random data
        for (int w = 0; w < 2; w++) begin
            run_req(lsu_op_pkg::MEMOP_SW, lsu_op_pkg::AMOOP_SWAP, 32'(32 + 4 * w), $urandom);
            for (int off = 0; off < 4; off++) begin
                run_req(lsu_op_pkg::MEMOP_LB, lsu_op_pkg::AMOOP_SWAP, 32'(32 + 4 * w + off), 0);
                run_req(lsu_op_pkg::MEMOP_LBU, lsu_op_pkg::AMOOP_SWAP, 32'(32 + 4 * w + off), 0);
            end
            for (int off = 0; off < 3; off++) begin
                run_req(lsu_op_pkg::MEMOP_LH, lsu_op_pkg::AMOOP_SWAP, 32'(32 + 4 * w + off), 0);
                run_req(lsu_op_pkg::MEMOP_LHU, lsu_op_pkg::AMOOP_SWAP, 32'(32 + 4 * w + off), 0);
            end
        end

        // all AMOs with random operands and then sign edge operands
        for (int k = 0; k < 9; k++) begin
            for (int t = 0; t < 2; t++) begin
                m = (t == 0) ? $urandom : 32'h8000_0001;
                s = (t == 0) ? $urandom : 32'h7fff_ffff;
                run_req(lsu_op_pkg::MEMOP_SW, lsu_op_pkg::AMOOP_SWAP, 32'h40, m);
                run_req(lsu_op_pkg::MEMOP_AMO, lsu_op_pkg::amoop_e'(4'(k)), 32'h40, s);
            end
        end

        // reservation hit, then none, a wrong address and a killing store
        run_req(lsu_op_pkg::MEMOP_LR_W, lsu_op_pkg::AMOOP_SWAP, 32'h50, 0);
        run_req(lsu_op_pkg::MEMOP_SC_W, lsu_op_pkg::AMOOP_SWAP, 32'h50, $urandom);
        run_req(lsu_op_pkg::MEMOP_SC_W, lsu_op_pkg::AMOOP_SWAP, 32'h50, $urandom);
        run_req(lsu_op_pkg::MEMOP_LR_W, lsu_op_pkg::AMOOP_SWAP, 32'h50, 0);
        run_req(lsu_op_pkg::MEMOP_SC_W, lsu_op_pkg::AMOOP_SWAP, 32'h54, $urandom);
        run_req(lsu_op_pkg::MEMOP_LR_W, lsu_op_pkg::AMOOP_SWAP, 32'h50, 0);
        run_req(lsu_op_pkg::MEMOP_SB, lsu_op_pkg::AMOOP_SWAP, 32'h51, $urandom);
        run_req(lsu_op_pkg::MEMOP_SC_W, lsu_op_pkg::AMOOP_SWAP, 32'h50, $urandom);
        run_req(lsu_op_pkg::MEMOP_LW, lsu_op_pkg::AMOOP_SWAP, 32'h50, 0);

        // misaligned word atomics are refused
        run_req(lsu_op_pkg::MEMOP_LR_W, lsu_op_pkg::AMOOP_SWAP, 32'h61, 0);
        run_req(lsu_op_pkg::MEMOP_SC_W, lsu_op_pkg::AMOOP_SWAP, 32'h62, $urandom);
        run_req(lsu_op_pkg::MEMOP_AMO, lsu_op_pkg::AMOOP_ADD, 32'h63, $urandom);
        run_req(lsu_op_pkg::MEMOP_LW, lsu_op_pkg::AMOOP_SWAP, 32'h60, 0);

        // no memory op hands the ALU result straight back
        run_req(lsu_op_pkg::MEMOP_NONE, lsu_op_pkg::AMOOP_SWAP, 32'h1234_5678, 0);

        repeat (4) @(posedge clk);
        $display("errors=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
